//--- test/i2c_input.txt
// id dev reg data refuse_at expected_nack queued, all hex
// refuse_at and expected_nack: 0 none, 1 device, 2 register, 3 data
01 50 00 a5 0 0 0
02 1a 3c 00 0 0 0
03 7f ff ff 0 0 0
04 00 81 7e 0 0 0
05 2d 10 55 1 1 0
06 48 22 aa 2 2 0
07 68 f0 0f 3 3 0
08 51 01 11 0 0 1
09 52 02 22 0 0 1
0a 53 03 33 2 2 1
0b 54 04 44 0 0 1
0c 55 05 55 3 3 1
0d 56 06 66 0 0 1

//--- tb.f
design/i2c_pkg.sv
design/i2c_cmd_queue.sv
design/scl_phase_timer.sv
design/i2c_bit_shifter.sv
design/i2c_write_fsm.sv
design/i2c_write_master.sv
test/i2c_slave_model.sv
test/tb_i2c_write_master.sv

//--- test/tb_i2c_write_master.sv
`timescale 1ns/1ps

module tb_i2c_write_master;

    localparam int NUM_LINES   = 13;
    localparam int LINE_W      = 7;       // words per line
    localparam int CYCLE_LIMIT = 500 * NUM_LINES + 200;

    logic                       clk;
    logic                       rstn;
    logic                       cmd_valid;
    logic [i2c_pkg::DEV_W-1:0]  cmd_dev;
    logic [i2c_pkg::REG_W-1:0]  cmd_reg;
    logic [i2c_pkg::DATA_W-1:0] cmd_data;
    logic                       credit;
    logic                       busy;
    logic                       done;
    i2c_pkg::nack_stage_t       nack_stage;
    logic                       scl;
    wire                        sda;

    logic [1:0] refuse_at;
    logic [6:0] rec_dev;
    logic       rec_rw;
    logic [7:0] rec_reg;
    logic [7:0] rec_data;
    logic [1:0] rec_bytes;
    logic [7:0] start_count;
    logic       stop_seen;
    logic       bus_active;

    logic [7:0] vec [NUM_LINES*LINE_W];
    int         push_q[$];
    int         credits;
    int         credit_pulses;
    int         pushes;
    int         done_count;
    int         busy_errors;
    int         cycles;
    bit         blocked;
    int         test_errors;
    int         tests;
    int         failed;

    pullup (sda);

    i2c_write_master i2c_write_master_inst (
        .clk        (clk),
        .rstn       (rstn),
        .cmd_valid  (cmd_valid),
        .cmd_dev    (cmd_dev),
        .cmd_reg    (cmd_reg),
        .cmd_data   (cmd_data),
        .credit     (credit),
        .busy       (busy),
        .done       (done),
        .nack_stage (nack_stage),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model i2c_slave_model_inst (
        .scl         (scl),
        .sda         (sda),
        .refuse_at   (refuse_at),
        .rec_dev     (rec_dev),
        .rec_rw      (rec_rw),
        .rec_reg     (rec_reg),
        .rec_data    (rec_data),
        .rec_bytes   (rec_bytes),
        .start_count (start_count),
        .stop_seen   (stop_seen),
        .active      (bus_active)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // column 0 id, 1 dev, 2 reg, 3 data, 4 refuse, 5 expected nack, 6 queued
    function automatic logic [7:0] field(input int line, input int col);
        return vec[line*LINE_W + col];
    endfunction

    function automatic string test_name(input int line);
        string kind;
        case (field(line, 4))
            8'd1:    kind = "nack_dev";
            8'd2:    kind = "nack_reg";
            8'd3:    kind = "nack_data";
            default: kind = "ack";
        endcase
        if (field(line, 6) != 8'd0)
            kind = {kind, "_queued"};
        return $sformatf("t%02h_%s", field(line, 0), kind);
    endfunction

    task automatic compare(input string name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s expected %0h actual %0h", name, what, expected, actual);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic close_test(input string name);
        tests = tests + 1;
        if (test_errors == 0) begin
            $display("pass %s", name);
        end else begin
            $display("fail %s with %0d errors", name, test_errors);
            failed = failed + 1;
        end
        test_errors = 0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (done !== 1'b1)
            @(negedge clk);
    endtask

    task automatic check_write(input int line);
        string name;
        int    refuse;
        name   = test_name(line);
        refuse = field(line, 4);
        wait_done();
        compare(name, "nack_stage", field(line, 5), nack_stage);
        compare(name, "bytes seen", (refuse == 0) ? 3 : refuse, rec_bytes);
        compare(name, "device", field(line, 1), rec_dev);
        compare(name, "rw bit", 0, rec_rw);
        if (refuse == 0 || refuse >= 2)
            compare(name, "register", field(line, 2), rec_reg);
        if (refuse == 0 || refuse == 3)
            compare(name, "data", field(line, 3), rec_data);
        compare(name, "stop seen", 1, stop_seen);
        compare(name, "scl", 1, scl);
        compare(name, "sda", 1, sda);
        close_test(name);
    endtask

    // host spends one credit per push
    initial begin : host_model
        int idx;
        forever begin
            @(posedge clk);
            #1;
            if (push_q.size() > 0 && credits > 0) begin
                idx       = push_q.pop_front();
                cmd_valid = 1'b1;
                cmd_dev   = 7'(field(idx, 1));
                cmd_reg   = field(idx, 2);
                cmd_data  = field(idx, 3);
                credits   = credits - 1;
                pushes    = pushes + 1;
            end else begin
                cmd_valid = 1'b0;
                if (push_q.size() > 0)
                    blocked = 1'b1;       // out of credits
            end
        end
    end

    always @(negedge clk) begin
        if (rstn === 1'b1) begin
            if (credit === 1'b1) begin
                credits       = credits + 1;
                credit_pulses = credit_pulses + 1;
            end
            if (done === 1'b1)
                done_count = done_count + 1;
            if (bus_active === 1'b1 && busy !== 1'b1) begin
                if (busy_errors == 0)
                    $display("busy is low while the bus is active at cycle %0d", cycles);
                busy_errors = busy_errors + 1;
            end
        end
    end

    initial begin
        int i;
        int j;
        int k;
        rstn          = 1'b0;
        cmd_valid     = 1'b0;
        cmd_dev       = '0;
        cmd_reg       = '0;
        cmd_data      = '0;
        refuse_at     = '0;
        credits       = i2c_pkg::QUEUE_DEPTH;
        credit_pulses = 0;
        pushes        = 0;
        done_count    = 0;
        busy_errors   = 0;
        cycles        = 0;
        blocked       = 1'b0;
        test_errors   = 0;
        tests         = 0;
        failed        = 0;
        $readmemh("test/i2c_input.txt", vec);
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        compare("reset", "scl", 1, scl);
        compare("reset", "sda", 1, sda);
        compare("reset", "busy", 0, busy);
        compare("reset", "done", 0, done);
        compare("reset", "credit", 0, credit);
        compare("reset", "starts seen", 0, start_count);
        close_test("reset");
        i = 0;
        while (i < NUM_LINES) begin
            j = i + 1;
            push_q.push_back(i);
            if (field(i, 6) != 8'd0) begin
                while (j < NUM_LINES && field(j, 6) != 8'd0) begin
                    push_q.push_back(j);
                    j = j + 1;
                end
            end
            blocked = 1'b0;
            for (k = i; k < j; k = k + 1) begin
                refuse_at = 2'(field(k, 4));
                check_write(k);
            end
            if (j - i > i2c_pkg::QUEUE_DEPTH) begin
                compare("credit_block", "host blocked", 1, blocked);
                close_test("credit_block");
            end
            i = j;
        end
        while (busy === 1'b1)
            @(negedge clk);
        compare("bookkeeping", "credits", i2c_pkg::QUEUE_DEPTH, credits);
        compare("bookkeeping", "pushes", NUM_LINES, pushes);
        compare("bookkeeping", "credit pulses", pushes, credit_pulses);
        compare("bookkeeping", "done pulses", NUM_LINES, done_count);
        compare("bookkeeping", "busy errors", 0, busy_errors);
        close_test("bookkeeping");
        $display("tests %0d, passed %0d, failed %0d", tests, tests - failed, failed);
        if (failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- test/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model (
    input  logic       scl,
    inout  wire        sda,
    input  logic [1:0] refuse_at,           // 0 none, 1 device, 2 register, 3 data
    output logic [6:0] rec_dev,
    output logic       rec_rw,
    output logic [7:0] rec_reg,
    output logic [7:0] rec_data,
    output logic [1:0] rec_bytes,
    output logic [7:0] start_count,
    output logic       stop_seen,
    output logic       active
);

    logic [7:0] shreg;
    logic [3:0] bit_cnt;                    // 8 is the ack clock
    logic       refused;
    logic       ack_drv;

    assign sda = ack_drv ? 1'b0 : 1'bz;

    initial begin
        active      = 1'b0;
        start_count = '0;
        stop_seen   = 1'b0;
        refused     = 1'b0;
        ack_drv     = 1'b0;
        bit_cnt     = '0;
        rec_bytes   = '0;
    end

    always @(negedge sda) begin
        if (scl === 1'b1 && sda === 1'b0) begin   // start
            active      = 1'b1;
            start_count = start_count + 1'b1;
            stop_seen   = 1'b0;
            refused     = 1'b0;
            bit_cnt     = '0;
            rec_bytes   = '0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && active === 1'b1) begin   // stop
            active    = 1'b0;
            stop_seen = 1'b1;
        end
    end

    always @(posedge scl) begin
        if (active === 1'b1 && !refused && !(rec_bytes == 2'd3 && bit_cnt == 4'd0)) begin
            if (bit_cnt < 4'd8) begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1'b1;
                if (bit_cnt == 4'd8) begin
                    case (rec_bytes)
                        2'd0: begin
                            rec_dev = shreg[7:1];
                            rec_rw  = shreg[0];
                        end
                        2'd1:    rec_reg  = shreg;
                        default: rec_data = shreg;
                    endcase
                    rec_bytes = rec_bytes + 1'b1;
                    refused   = (rec_bytes == refuse_at);
                end
            end else begin
                bit_cnt = 4'd9;             // ack clock seen
            end
        end
    end

    always @(negedge scl) begin
        if (active === 1'b1 && !refused && bit_cnt == 4'd8) begin
            ack_drv = 1'b1;
        end else if (bit_cnt == 4'd9) begin
            ack_drv = 1'b0;                 // end of ack slot
            bit_cnt = '0;
        end
    end

endmodule

//--- design/i2c_write_master.sv
`timescale 1ns/1ps

module i2c_write_master (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        cmd_valid,
    input  logic [i2c_pkg::DEV_W-1:0]   cmd_dev,
    input  logic [i2c_pkg::REG_W-1:0]   cmd_reg,
    input  logic [i2c_pkg::DATA_W-1:0]  cmd_data,
    output logic                        credit,
    output logic                        busy,
    output logic                        done,
    output i2c_pkg::nack_stage_t        nack_stage,
    output logic                        scl,
    inout  wire                         sda
);

    logic                       q_empty;
    logic                       q_pop;
    logic [i2c_pkg::DEV_W-1:0]  q_dev;
    logic [i2c_pkg::REG_W-1:0]  q_reg;
    logic [i2c_pkg::DATA_W-1:0] q_data;
    logic                       tmr_run;
    logic                       ph_rise;
    logic                       ph_mid;
    logic                       ph_fall;
    logic                       ph_end;
    logic                       sh_load;
    logic [i2c_pkg::DATA_W-1:0] load_byte;
    logic                       sh_shift;
    logic                       sh_bit;
    logic                       sh_last;
    logic                       ack_n;
    logic                       sda_oe;
    logic                       sda_in;

    // open drain with external pull-up
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

    i2c_cmd_queue i2c_cmd_queue_inst (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid),
        .cmd_dev   (cmd_dev),
        .cmd_reg   (cmd_reg),
        .cmd_data  (cmd_data),
        .q_pop     (q_pop),
        .q_empty   (q_empty),
        .q_dev     (q_dev),
        .q_reg     (q_reg),
        .q_data    (q_data),
        .credit    (credit)
    );

    scl_phase_timer scl_phase_timer_inst (
        .clk     (clk),
        .rstn    (rstn),
        .tmr_run (tmr_run),
        .ph_rise (ph_rise),
        .ph_mid  (ph_mid),
        .ph_fall (ph_fall),
        .ph_end  (ph_end)
    );

    i2c_bit_shifter i2c_bit_shifter_inst (
        .clk       (clk),
        .rstn      (rstn),
        .sh_load   (sh_load),
        .load_byte (load_byte),
        .sh_shift  (sh_shift),
        .sda_in    (sda_in),
        .ph_mid    (ph_mid),
        .sh_bit    (sh_bit),
        .sh_last   (sh_last),
        .ack_n     (ack_n)
    );

    i2c_write_fsm i2c_write_fsm_inst (
        .clk        (clk),
        .rstn       (rstn),
        .q_empty    (q_empty),
        .q_dev      (q_dev),
        .q_reg      (q_reg),
        .q_data     (q_data),
        .ph_rise    (ph_rise),
        .ph_mid     (ph_mid),
        .ph_fall    (ph_fall),
        .ph_end     (ph_end),
        .sh_bit     (sh_bit),
        .sh_last    (sh_last),
        .ack_n      (ack_n),
        .q_pop      (q_pop),
        .tmr_run    (tmr_run),
        .sh_load    (sh_load),
        .load_byte  (load_byte),
        .sh_shift   (sh_shift),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .busy       (busy),
        .done       (done),
        .nack_stage (nack_stage)
    );

endmodule

//--- design/i2c_write_fsm.sv
`timescale 1ns/1ps

module i2c_write_fsm (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        q_empty,
    input  logic [i2c_pkg::DEV_W-1:0]   q_dev,
    input  logic [i2c_pkg::REG_W-1:0]   q_reg,
    input  logic [i2c_pkg::DATA_W-1:0]  q_data,
    input  logic                        ph_rise,
    input  logic                        ph_mid,
    input  logic                        ph_fall,
    input  logic                        ph_end,
    input  logic                        sh_bit,
    input  logic                        sh_last,
    input  logic                        ack_n,
    output logic                        q_pop,
    output logic                        tmr_run,
    output logic                        sh_load,
    output logic [i2c_pkg::DATA_W-1:0]  load_byte,
    output logic                        sh_shift,
    output logic                        scl,
    output logic                        sda_oe,
    output logic                        busy,
    output logic                        done,
    output i2c_pkg::nack_stage_t        nack_stage
);

    i2c_pkg::state_t state;
    logic            pop_d;                   // popped fields valid
    logic            sda_drv;                 // low drive for start/stop
    logic            in_byte;
    logic            in_ack;

    assign in_byte = (state == i2c_pkg::addr_byte) || (state == i2c_pkg::reg_byte) ||
                     (state == i2c_pkg::data_byte);
    assign in_ack  = (state == i2c_pkg::addr_ack) || (state == i2c_pkg::reg_ack) ||
                     (state == i2c_pkg::data_ack);

    assign tmr_run  = (state != i2c_pkg::idle);
    assign q_pop    = (state == i2c_pkg::idle) && !q_empty && !pop_d;
    assign sh_shift = in_byte && ph_end && !sh_last;
    assign sh_load  = pop_d || (ph_end && !ack_n &&
                      ((state == i2c_pkg::addr_ack) || (state == i2c_pkg::reg_ack)));

    always_comb begin
        case (state)
            i2c_pkg::addr_ack: load_byte = q_reg;
            i2c_pkg::reg_ack:  load_byte = q_data;
            default:           load_byte = {q_dev, 1'b0};   // write bit
        endcase
    end

    // a 1 on sh_bit means released
    assign sda_oe = in_byte ? !sh_bit : (in_ack ? 1'b0 : sda_drv);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= i2c_pkg::idle;
            pop_d      <= 1'b0;
            scl        <= 1'b1;
            sda_drv    <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            nack_stage <= i2c_pkg::nack_none;
        end else begin
            pop_d <= q_pop;
            done  <= 1'b0;
            if (q_pop)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
            if (ph_rise)
                scl <= 1'b1;
            else if (ph_fall && state != i2c_pkg::stop)
                scl <= 1'b0;                  // stays high after stop
            case (state)
                i2c_pkg::idle: begin
                    if (pop_d) begin
                        state      <= i2c_pkg::start;
                        nack_stage <= i2c_pkg::nack_none;
                    end
                end
                i2c_pkg::start: begin
                    if (ph_mid)
                        sda_drv <= 1'b1;      // sda falls while scl high
                    if (ph_end)
                        state <= i2c_pkg::addr_byte;
                end
                i2c_pkg::addr_byte: begin
                    if (ph_end && sh_last)
                        state <= i2c_pkg::addr_ack;
                end
                i2c_pkg::reg_byte: begin
                    if (ph_end && sh_last)
                        state <= i2c_pkg::reg_ack;
                end
                i2c_pkg::data_byte: begin
                    if (ph_end && sh_last)
                        state <= i2c_pkg::data_ack;
                end
                i2c_pkg::addr_ack: begin
                    if (ph_end && ack_n) begin
                        nack_stage <= i2c_pkg::nack_dev;
                        state      <= i2c_pkg::stop;
                    end else if (ph_end) begin
                        state <= i2c_pkg::reg_byte;
                    end
                end
                i2c_pkg::reg_ack: begin
                    if (ph_end && ack_n) begin
                        nack_stage <= i2c_pkg::nack_reg;
                        state      <= i2c_pkg::stop;
                    end else if (ph_end) begin
                        state <= i2c_pkg::data_byte;
                    end
                end
                i2c_pkg::data_ack: begin
                    if (ph_end) begin
                        if (ack_n)
                            nack_stage <= i2c_pkg::nack_data;
                        state <= i2c_pkg::stop;
                    end
                end
                i2c_pkg::stop: begin
                    // sda still driven low from start until mid period
                    if (ph_mid)
                        sda_drv <= 1'b0;
                    if (ph_end) begin
                        state <= i2c_pkg::idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= i2c_pkg::idle;
            endcase
        end
    end

endmodule

//--- design/i2c_bit_shifter.sv
`timescale 1ns/1ps

module i2c_bit_shifter (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        sh_load,
    input  logic [i2c_pkg::DATA_W-1:0]  load_byte,
    input  logic                        sh_shift,
    input  logic                        sda_in,
    input  logic                        ph_mid,
    output logic                        sh_bit,
    output logic                        sh_last,
    output logic                        ack_n
);

    logic [i2c_pkg::DATA_W-1:0]         shreg;
    logic [$clog2(i2c_pkg::DATA_W)-1:0] bit_idx;

    always_ff @(posedge clk) begin
        if (sh_load)
            shreg <= load_byte;
        else if (sh_shift)
            shreg <= {shreg[i2c_pkg::DATA_W-2:0], 1'b0};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bit_idx <= '0;
            ack_n   <= 1'b1;
        end else begin
            if (sh_load)
                bit_idx <= '0;
            else if (sh_shift)
                bit_idx <= bit_idx + 1'b1;
            if (ph_mid)
                ack_n <= sda_in;              // scl is high here
        end
    end

    assign sh_bit  = shreg[i2c_pkg::DATA_W-1];   // msb first
    assign sh_last = (bit_idx == i2c_pkg::DATA_W - 1);

endmodule

//--- design/scl_phase_timer.sv
`timescale 1ns/1ps

module scl_phase_timer (
    input  logic clk,
    input  logic rstn,
    input  logic tmr_run,
    output logic ph_rise,
    output logic ph_mid,
    output logic ph_fall,
    output logic ph_end
);

    logic [$clog2(i2c_pkg::SCL_DIV)-1:0] cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            cnt <= '0;
        else if (!tmr_run)
            cnt <= '0;                        // next period starts from zero
        else if (cnt == i2c_pkg::PH_END)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    assign ph_rise = tmr_run && (cnt == i2c_pkg::PH_RISE);
    assign ph_mid  = tmr_run && (cnt == i2c_pkg::PH_MID);
    assign ph_fall = tmr_run && (cnt == i2c_pkg::PH_FALL);
    assign ph_end  = tmr_run && (cnt == i2c_pkg::PH_END);

endmodule

//--- design/i2c_cmd_queue.sv
`timescale 1ns/1ps

module i2c_cmd_queue (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        cmd_valid,
    input  logic [i2c_pkg::DEV_W-1:0]   cmd_dev,
    input  logic [i2c_pkg::REG_W-1:0]   cmd_reg,
    input  logic [i2c_pkg::DATA_W-1:0]  cmd_data,
    input  logic                        q_pop,
    output logic                        q_empty,
    output logic [i2c_pkg::DEV_W-1:0]   q_dev,
    output logic [i2c_pkg::REG_W-1:0]   q_reg,
    output logic [i2c_pkg::DATA_W-1:0]  q_data,
    output logic                        credit
);

    logic [i2c_pkg::DEV_W-1:0]  mem_dev  [i2c_pkg::QUEUE_DEPTH];
    logic [i2c_pkg::REG_W-1:0]  mem_reg  [i2c_pkg::QUEUE_DEPTH];
    logic [i2c_pkg::DATA_W-1:0] mem_data [i2c_pkg::QUEUE_DEPTH];

    logic [$clog2(i2c_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(i2c_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(i2c_pkg::QUEUE_DEPTH):0]   count;   // occupancy

    assign q_empty = (count == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= q_pop;                  // one credit back per pop
            if (cmd_valid)
                wr_ptr <= wr_ptr + 1'b1;      // depth is a power of two
            if (q_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (cmd_valid && !q_pop)
                count <= count + 1'b1;
            else if (!cmd_valid && q_pop)
                count <= count - 1'b1;
        end
    end

    // room is guaranteed by the host's credits
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem_dev[wr_ptr]  <= cmd_dev;
            mem_reg[wr_ptr]  <= cmd_reg;
            mem_data[wr_ptr] <= cmd_data;
        end
        if (q_pop) begin
            q_dev  <= mem_dev[rd_ptr];
            q_reg  <= mem_reg[rd_ptr];
            q_data <= mem_data[rd_ptr];
        end
    end

endmodule

//--- design/i2c_pkg.sv
package i2c_pkg;

    // bus timing in clk cycles
    localparam int SCL_DIV = 16;                 // one bit period
    localparam int PH_RISE = SCL_DIV / 4;        // scl goes high
    localparam int PH_MID  = SCL_DIV / 2;        // sda sample, start/stop edge
    localparam int PH_FALL = SCL_DIV * 3 / 4;    // scl goes low
    localparam int PH_END  = SCL_DIV - 1;        // last cycle of the period

    // command fields
    localparam int DEV_W  = 7;
    localparam int REG_W  = 8;
    localparam int DATA_W = 8;

    // entries in the command queue, also the host's credits after reset
    localparam int QUEUE_DEPTH = 4;

    typedef enum logic [3:0] {
        idle,
        start,
        addr_byte,
        addr_ack,
        reg_byte,
        reg_ack,
        data_byte,
        data_ack,
        stop
    } state_t;

    // where the slave refused the transfer
    typedef enum logic [1:0] {
        nack_none,
        nack_dev,
        nack_reg,
        nack_data
    } nack_stage_t;

endpackage
